//--- vlog.f
rtl/mips_pkg.sv
rtl/reg_file.sv
rtl/fetch_stage.sv
rtl/hazard_unit.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/mips_core.sv
sim/tb_mem_model.sv
sim/tb_mips_core.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := tb_mips_core
FLIST     := vlog.f
TRACE     := sim/mips_trace.txt
LOG       := sim.log

SRCS := $(shell cat $(FLIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN) $(TRACE)
	./$(BIN) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- sim/mips_trace.txt
# P byte_addr word / D byte_addr word / F byte_addr final_word (hex)
# E pc reg value: expected writeback events in order (hex)
P 00 3c011234
P 04 34215678
P 08 2402fffc
P 0c 3043ff0f
P 10 00222021
P 14 00812823
P 18 00a0302a
P 1c 00a0382b
P 20 00054043
P 24 00054902
P 28 00015200
P 2c 00205827
P 30 00246026
P 34 284dfffd
P 38 386e00ff
P 3c ac010000
P 40 8c0f0004
P 44 01ef8021
P 48 120f0004
P 4c 24110001
P 50 160f0003
P 54 24120002
P 58 24130077
P 5c 24130088
P 60 0c00001c
P 64 ac100008
P 68 24140055
P 6c 10000004
P 70 8c150008
P 74 03e00008
P 78 26b60001
P 7c 24170099
P 80 08000020
P 84 00000000
D 04 00000005
D 0c cafef00d
E 00 01 12340000
E 04 01 12345678
E 08 02 fffffffc
E 0c 03 0000ff0c
E 10 04 12345674
E 14 05 fffffffc
E 18 06 00000001
E 1c 07 00000000
E 20 08 fffffffe
E 24 09 0fffffff
E 28 0a 34567800
E 2c 0b edcba987
E 30 0c 0000000c
E 34 0d 00000001
E 38 0e 0000fff3
E 40 0f 00000005
E 44 10 0000000a
E 4c 11 00000001
E 54 12 00000002
E 60 1f 00000068
E 70 15 0000000a
E 78 16 0000000b
E 68 14 00000055
E 70 15 0000000a
F 00 12345678
F 04 00000005
F 08 0000000a
F 0c cafef00d

//--- sim/tb_mips_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mips_core;
   logic        clk;
   logic        rst;
   logic [31:0] inst_addr, inst_data, data_addr, data_wdata, data_rdata;
   logic        data_en, data_we;
   logic [31:0] wb_pc, wb_data;
   logic        wb_wen;
   logic [4:0]  wb_num;
   int          passed;
   int          failed;
   logic [31:0] exp_pc[$];
   logic [31:0] exp_reg[$];
   logic [31:0] exp_val[$];
   logic [31:0] fin_addr[$];
   logic [31:0] fin_word[$];

   mips_core #(.RESET_PC(32'h0000_0000)) i_dut (
      .clk, .rst,
      .inst_addr_o   (inst_addr),
      .inst_data_i   (inst_data),
      .data_en_o     (data_en),
      .data_we_o     (data_we),
      .data_addr_o   (data_addr),
      .data_wdata_o  (data_wdata),
      .data_rdata_i  (data_rdata),
      .wb_pc_o       (wb_pc),
      .wb_rf_wen_o   (wb_wen),
      .wb_rf_wnum_o  (wb_num),
      .wb_rf_wdata_o (wb_data)
   );

   tb_mem_model i_mem (
      .clk,
      .inst_addr_i  (inst_addr),
      .inst_data_o  (inst_data),
      .data_en_i    (data_en),
      .data_we_i    (data_we),
      .data_addr_i  (data_addr),
      .data_wdata_i (data_wdata),
      .data_rdata_o (data_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic read_expected();
      int          fd;
      int          n;
      string       line;
      byte         kind;
      logic [31:0] a, b, c;
      fd = $fopen("sim/mips_trace.txt", "r");
      if (fd == 0) begin
         $display("cannot open sim/mips_trace.txt");
         return;
      end
      while (!$feof(fd)) begin
         n = $fgets(line, fd);
         if (n > 0 && line[0] != "#") begin
            n = $sscanf(line, "%c %h %h %h", kind, a, b, c);
            if (kind == "E" && n == 4) begin
               exp_pc.push_back(a);
               exp_reg.push_back(b);
               exp_val.push_back(c);
            end else if (kind == "F" && n == 3) begin
               fin_addr.push_back(a);
               fin_word.push_back(b);
            end
         end
      end
      $fclose(fd);
   endtask

   // Sampled on the falling edge, away from the DUT's updates
   task automatic wait_writeback(output bit seen);
      int cycles;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!wb_wen && cycles < 200);
      seen = wb_wen;
   endtask

   function automatic bit compare_word(string name, string field,
                                       logic [31:0] expected, logic [31:0] actual);
      if (expected !== actual) begin
         $display("ERR %s %s expected %h actual %h", name, field, expected, actual);
         return 1'b0;
      end
      return 1'b1;
   endfunction

   task automatic record_result(string name, bit ok);
      if (ok) begin
         passed++;
         $display("PASS %s", name);
      end else begin
         failed++;
         $display("FAIL %s", name);
      end
   endtask

   initial begin
      string      name;
      bit         ok;
      bit         seen;
      int         extra;
      logic [7:0] idx;
      rst    = 1'b1;
      passed = 0;
      failed = 0;
      read_expected();
      repeat (8) @(negedge clk);
      rst = 1'b0;

      foreach (exp_pc[i]) begin
         name = $sformatf("wb%0d", i);
         wait_writeback(seen);
         if (!seen) begin
            $display("timeout waiting for writeback in %s", name);
            $display("Test failed");
            $finish;
         end
         ok = compare_word(name, "pc", exp_pc[i], wb_pc);
         ok = compare_word(name, "reg", exp_reg[i], {27'd0, wb_num}) && ok;
         ok = compare_word(name, "value", exp_val[i], wb_data) && ok;
         record_result(name, ok);
      end

      // Squashed slots and the final loop must stay off the trace
      extra = 0;
      repeat (40) begin
         @(negedge clk);
         if (wb_wen)
            extra++;
      end
      if (extra != 0)
         $display("unexpected writeback after the last expected event");
      record_result("quiet", extra == 0);

      foreach (fin_addr[i]) begin
         idx  = fin_addr[i][9:2];
         name = $sformatf("mem%h", fin_addr[i]);
         record_result(name, compare_word(name, "word", fin_word[i], i_mem.dmem[idx]));
      end

      if (exp_pc.size() == 0) begin
         $display("no expected writeback events were read");
         failed++;
      end
      $display("%0d tests passed, %0d tests failed", passed, failed);
      if (failed == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/tb_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model (
   input  wire         clk,
   input  wire  [31:0] inst_addr_i,
   output logic [31:0] inst_data_o,
   input  wire         data_en_i,
   input  wire         data_we_i,
   input  wire  [31:0] data_addr_i,
   input  wire  [31:0] data_wdata_i,
   output logic [31:0] data_rdata_o
);
   logic [31:0] imem [256];
   logic [31:0] dmem [256];
   logic [31:0] inst_q  = '0;
   logic [31:0] rdata_q = '0;

   initial begin : load_trace
      int          fd;
      int          n;
      string       line;
      byte         kind;
      logic [31:0] addr;
      logic [31:0] word;
      // Opcode 6'h3f is undefined, so stray fetches act as no-ops
      for (int i = 0; i < 256; i++) begin
         imem[i] = {6'h3f, 16'd0, i[7:0], 2'b00};
         dmem[i] = {16'h5a5a, 6'd0, i[7:0], 2'b00};
      end
      fd = $fopen("sim/mips_trace.txt", "r");
      if (fd == 0) begin
         $display("cannot open sim/mips_trace.txt");
      end else begin
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#") begin
               n = $sscanf(line, "%c %h %h", kind, addr, word);
               if (n == 3 && kind == "P")
                  imem[addr[9:2]] = word;
               else if (n == 3 && kind == "D")
                  dmem[addr[9:2]] = word;
            end
         end
         $fclose(fd);
      end
   end

   always @(posedge clk) begin
      inst_q <= imem[inst_addr_i[9:2]];
      if (data_en_i) begin
         rdata_q <= dmem[data_addr_i[9:2]];
         if (data_we_i)
            dmem[data_addr_i[9:2]] = data_wdata_i;
      end
   end

   assign inst_data_o  = inst_q;
   assign data_rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- rtl/mips_core.sv
`timescale 1ns/10ps
`default_nettype none

module mips_core #(
   parameter logic [mips_pkg::XLEN-1:0] RESET_PC = 32'h0000_0000
) (
   input  wire                              clk,
   input  wire                              rst,
   output logic [mips_pkg::XLEN-1:0]        inst_addr_o,
   input  wire  [mips_pkg::XLEN-1:0]        inst_data_i,
   output logic                             data_en_o,
   output logic                             data_we_o,
   output logic [mips_pkg::XLEN-1:0]        data_addr_o,
   output logic [mips_pkg::XLEN-1:0]        data_wdata_o,
   input  wire  [mips_pkg::XLEN-1:0]        data_rdata_i,
   output logic [mips_pkg::XLEN-1:0]        wb_pc_o,
   output logic                             wb_rf_wen_o,
   output logic [mips_pkg::REG_ADDR_W-1:0]  wb_rf_wnum_o,
   output logic [mips_pkg::XLEN-1:0]        wb_rf_wdata_o
);
   mips_pkg::if_id_t                if_id;
   mips_pkg::id_ex_t                id_ex;
   mips_pkg::ex_mem_t               ex_mem;
   mips_pkg::mem_wb_t               mem_wb;
   mips_pkg::fwd_sel_e              fwd_a, fwd_b;
   logic                            stall, squash, redirect, wb_wen;
   logic [mips_pkg::XLEN-1:0]       target, ex_result, mem_result, rf_a, rf_b;
   logic [mips_pkg::REG_ADDR_W-1:0] rs, rt;

   fetch_stage #(.RESET_PC(RESET_PC)) i_fetch (
      .clk, .rst,
      .stall_i     (stall),
      .squash_i    (squash),
      .redirect_i  (redirect),
      .target_i    (target),
      .inst_addr_o (inst_addr_o),
      .if_id_o     (if_id)
   );

   decode_stage i_decode (
      .clk, .rst,
      .stall_i      (stall),
      .if_id_i      (if_id),
      .inst_i       (inst_data_i),
      .rf_a_i       (rf_a),
      .rf_b_i       (rf_b),
      .fwd_a_i      (fwd_a),
      .fwd_b_i      (fwd_b),
      .ex_result_i  (ex_result),
      .mem_result_i (mem_result),
      .rs_o         (rs),
      .rt_o         (rt),
      .id_ex_o      (id_ex)
   );

   reg_file i_reg_file (
      .clk, .rst,
      .raddr_a_i (rs),
      .raddr_b_i (rt),
      .rdata_a_o (rf_a),
      .rdata_b_o (rf_b),
      .wen_i     (wb_wen),
      .waddr_i   (mem_wb.wb_dest),
      .wdata_i   (mem_wb.wb_data)
   );

   hazard_unit i_hazard (
      .rs_i       (rs),
      .rt_i       (rt),
      .id_ex_i    (id_ex),
      .ex_mem_i   (ex_mem),
      .redirect_i (redirect),
      .stall_o    (stall),
      .squash_o   (squash),
      .fwd_a_o    (fwd_a),
      .fwd_b_o    (fwd_b)
   );

   execute_stage i_execute (
      .clk, .rst,
      .id_ex_i      (id_ex),
      .redirect_o   (redirect),
      .target_o     (target),
      .ex_result_o  (ex_result),
      .data_en_o    (data_en_o),
      .data_we_o    (data_we_o),
      .data_addr_o  (data_addr_o),
      .data_wdata_o (data_wdata_o),
      .ex_mem_o     (ex_mem)
   );

   memory_stage i_memory (
      .clk, .rst,
      .ex_mem_i     (ex_mem),
      .data_rdata_i (data_rdata_i),
      .mem_result_o (mem_result),
      .mem_wb_o     (mem_wb)
   );

   assign wb_wen        = mem_wb.valid & mem_wb.wb_en;
   assign wb_pc_o       = mem_wb.pc;
   assign wb_rf_wen_o   = wb_wen;
   assign wb_rf_wnum_o  = mem_wb.wb_dest;
   assign wb_rf_wdata_o = mem_wb.wb_data;

endmodule

`default_nettype wire

//--- rtl/memory_stage.sv
`timescale 1ns/10ps
`default_nettype none

module memory_stage (
   input  wire                       clk,
   input  wire                       rst,
   input  wire  mips_pkg::ex_mem_t   ex_mem_i,
   input  wire  [mips_pkg::XLEN-1:0] data_rdata_i,
   output logic [mips_pkg::XLEN-1:0] mem_result_o,
   output mips_pkg::mem_wb_t         mem_wb_o
);
   // Load data returns the cycle after the execute request
   assign mem_result_o = ex_mem_i.mem_read ? data_rdata_i : ex_mem_i.result;

   always_ff @(posedge clk) begin
      if (rst) begin
         mem_wb_o.valid <= 1'b0;
         mem_wb_o.wb_en <= 1'b0;
      end else begin
         mem_wb_o.valid   <= ex_mem_i.valid;
         mem_wb_o.pc      <= ex_mem_i.pc;
         mem_wb_o.wb_en   <= ex_mem_i.wb_en;
         mem_wb_o.wb_dest <= ex_mem_i.wb_dest;
         mem_wb_o.wb_data <= mem_result_o;
      end
   end

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
   input  wire                       clk,
   input  wire                       rst,
   input  wire  mips_pkg::id_ex_t    id_ex_i,
   output logic                      redirect_o,
   output logic [mips_pkg::XLEN-1:0] target_o,
   output logic [mips_pkg::XLEN-1:0] ex_result_o,
   output logic                      data_en_o,
   output logic                      data_we_o,
   output logic [mips_pkg::XLEN-1:0] data_addr_o,
   output logic [mips_pkg::XLEN-1:0] data_wdata_o,
   output mips_pkg::ex_mem_t         ex_mem_o
);
   logic [mips_pkg::XLEN-1:0] a, b, pc_plus4;
   logic                      taken;

   assign a        = id_ex_i.src_a;
   assign b        = id_ex_i.src_b;
   assign pc_plus4 = id_ex_i.pc + 32'd4;

   always_comb begin
      case (id_ex_i.alu_op)
         mips_pkg::ALU_SUB:  ex_result_o = a - b;
         mips_pkg::ALU_AND:  ex_result_o = a & b;
         mips_pkg::ALU_OR:   ex_result_o = a | b;
         mips_pkg::ALU_XOR:  ex_result_o = a ^ b;
         mips_pkg::ALU_NOR:  ex_result_o = ~(a | b);
         mips_pkg::ALU_SLT:  ex_result_o = {31'd0, $signed(a) < $signed(b)};
         mips_pkg::ALU_SLTU: ex_result_o = {31'd0, a < b};
         mips_pkg::ALU_SLL:  ex_result_o = b << a[4:0];
         mips_pkg::ALU_SRL:  ex_result_o = b >> a[4:0];
         mips_pkg::ALU_SRA:  ex_result_o = $unsigned($signed(b) >>> a[4:0]);
         mips_pkg::ALU_LUI:  ex_result_o = {b[15:0], 16'd0};
         default:            ex_result_o = a + b;
      endcase
   end

   // Branch operands are rs on A and rt in rt_data
   always_comb begin
      case (id_ex_i.branch)
         mips_pkg::BR_BEQ: taken = id_ex_i.src_a == id_ex_i.rt_data;
         mips_pkg::BR_BNE: taken = id_ex_i.src_a != id_ex_i.rt_data;
         mips_pkg::BR_J,
         mips_pkg::BR_JAL,
         mips_pkg::BR_JR:  taken = 1'b1;
         default:          taken = 1'b0;
      endcase
      case (id_ex_i.branch)
         mips_pkg::BR_JR:  target_o = id_ex_i.src_a;
         mips_pkg::BR_J,
         mips_pkg::BR_JAL: target_o = {pc_plus4[31:28], id_ex_i.target, 2'b00};
         default: target_o = pc_plus4 + {{14{id_ex_i.target[15]}}, id_ex_i.target[15:0], 2'b00};
      endcase
   end

   assign redirect_o   = id_ex_i.valid & taken;
   assign data_en_o    = id_ex_i.valid & (id_ex_i.mem_read | id_ex_i.mem_write);
   assign data_we_o    = id_ex_i.valid & id_ex_i.mem_write;
   assign data_addr_o  = ex_result_o;
   assign data_wdata_o = id_ex_i.rt_data;

   always_ff @(posedge clk) begin
      if (rst) begin
         ex_mem_o.valid    <= 1'b0;
         ex_mem_o.mem_read <= 1'b0;
         ex_mem_o.wb_en    <= 1'b0;
      end else begin
         ex_mem_o.valid    <= id_ex_i.valid;
         ex_mem_o.pc       <= id_ex_i.pc;
         ex_mem_o.result   <= ex_result_o;
         ex_mem_o.mem_read <= id_ex_i.mem_read;
         ex_mem_o.wb_en    <= id_ex_i.wb_en;
         ex_mem_o.wb_dest  <= id_ex_i.wb_dest;
      end
   end

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
   input  wire                             clk,
   input  wire                             rst,
   input  wire                             stall_i,
   input  wire  mips_pkg::if_id_t          if_id_i,
   input  wire  mips_pkg::instr_u          inst_i,
   input  wire  [mips_pkg::XLEN-1:0]       rf_a_i,
   input  wire  [mips_pkg::XLEN-1:0]       rf_b_i,
   input  wire  mips_pkg::fwd_sel_e        fwd_a_i,
   input  wire  mips_pkg::fwd_sel_e        fwd_b_i,
   input  wire  [mips_pkg::XLEN-1:0]       ex_result_i,
   input  wire  [mips_pkg::XLEN-1:0]       mem_result_i,
   output logic [mips_pkg::REG_ADDR_W-1:0] rs_o,
   output logic [mips_pkg::REG_ADDR_W-1:0] rt_o,
   output mips_pkg::id_ex_t                id_ex_o
);
   mips_pkg::id_ex_t                id_ex_d;
   mips_pkg::alu_op_e               alu_op;
   mips_pkg::src_a_e                src_a;
   mips_pkg::src_b_e                src_b;
   mips_pkg::branch_e               branch;
   logic                            mem_read, mem_write, wb_en, is_jtype;
   logic [mips_pkg::REG_ADDR_W-1:0] wb_dest;
   logic [mips_pkg::XLEN-1:0]       rs_val, rt_val;

   function automatic logic [mips_pkg::XLEN-1:0] fwd_mux(
      input mips_pkg::fwd_sel_e        sel,
      input logic [mips_pkg::XLEN-1:0] rf,
      input logic [mips_pkg::XLEN-1:0] ex,
      input logic [mips_pkg::XLEN-1:0] mem
   );
      case (sel)
         mips_pkg::FWD_EX:  return ex;
         mips_pkg::FWD_MEM: return mem;
         default:           return rf;
      endcase
   endfunction

   // J and JAL read r0 on both ports, so JAL sees zero on operand B
   assign is_jtype = inst_i.i.opcode inside {mips_pkg::OP_J, mips_pkg::OP_JAL};
   assign rs_o     = is_jtype ? '0 : inst_i.i.rs;
   assign rt_o     = is_jtype ? '0 : inst_i.i.rt;
   assign rs_val   = fwd_mux(fwd_a_i, rf_a_i, ex_result_i, mem_result_i);
   assign rt_val   = fwd_mux(fwd_b_i, rf_b_i, ex_result_i, mem_result_i);

   always_comb begin
      alu_op    = mips_pkg::ALU_ADD;
      src_a     = mips_pkg::SRC_A_REG;
      src_b     = mips_pkg::SRC_B_REG;
      branch    = mips_pkg::BR_NONE;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      wb_en     = 1'b1;
      wb_dest   = inst_i.i.rt;
      case (inst_i.i.opcode)
         mips_pkg::OP_SPECIAL: begin
            wb_dest = inst_i.r.rd;
            case (inst_i.r.funct)
               mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
               mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
               mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
               mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
               mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
               mips_pkg::FN_NOR:  alu_op = mips_pkg::ALU_NOR;
               mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
               mips_pkg::FN_SLTU: alu_op = mips_pkg::ALU_SLTU;
               mips_pkg::FN_SLL,
               mips_pkg::FN_SRL,
               mips_pkg::FN_SRA: begin
                  src_a  = mips_pkg::SRC_A_SHAMT;
                  alu_op = (inst_i.r.funct == mips_pkg::FN_SLL) ? mips_pkg::ALU_SLL :
                           (inst_i.r.funct == mips_pkg::FN_SRL) ? mips_pkg::ALU_SRL :
                                                                  mips_pkg::ALU_SRA;
               end
               mips_pkg::FN_JR: begin
                  branch = mips_pkg::BR_JR;
                  wb_en  = 1'b0;
               end
               default: wb_en = 1'b0;
            endcase
         end
         mips_pkg::OP_ADDIU: src_b = mips_pkg::SRC_B_SEXT;
         mips_pkg::OP_SLTI: begin
            alu_op = mips_pkg::ALU_SLT;
            src_b  = mips_pkg::SRC_B_SEXT;
         end
         mips_pkg::OP_ANDI: begin
            alu_op = mips_pkg::ALU_AND;
            src_b  = mips_pkg::SRC_B_ZEXT;
         end
         mips_pkg::OP_ORI: begin
            alu_op = mips_pkg::ALU_OR;
            src_b  = mips_pkg::SRC_B_ZEXT;
         end
         mips_pkg::OP_XORI: begin
            alu_op = mips_pkg::ALU_XOR;
            src_b  = mips_pkg::SRC_B_ZEXT;
         end
         mips_pkg::OP_LUI: begin
            alu_op = mips_pkg::ALU_LUI;
            src_b  = mips_pkg::SRC_B_ZEXT;
         end
         mips_pkg::OP_LW: begin
            src_b    = mips_pkg::SRC_B_SEXT;
            mem_read = 1'b1;
         end
         mips_pkg::OP_SW: begin
            src_b     = mips_pkg::SRC_B_SEXT;
            mem_write = 1'b1;
            wb_en     = 1'b0;
         end
         mips_pkg::OP_BEQ: begin
            branch = mips_pkg::BR_BEQ;
            wb_en  = 1'b0;
         end
         mips_pkg::OP_BNE: begin
            branch = mips_pkg::BR_BNE;
            wb_en  = 1'b0;
         end
         mips_pkg::OP_J: begin
            branch = mips_pkg::BR_J;
            wb_en  = 1'b0;
         end
         mips_pkg::OP_JAL: begin
            branch  = mips_pkg::BR_JAL;
            src_a   = mips_pkg::SRC_A_PC8;
            wb_dest = 5'd31;
         end
         default: wb_en = 1'b0;
      endcase
   end

   always_comb begin
      id_ex_d.valid     = if_id_i.valid;
      id_ex_d.pc        = if_id_i.pc;
      id_ex_d.alu_op    = alu_op;
      case (src_a)
         mips_pkg::SRC_A_SHAMT: id_ex_d.src_a = {27'd0, inst_i.r.shamt};
         mips_pkg::SRC_A_PC8:   id_ex_d.src_a = if_id_i.pc + 32'd8;
         default:               id_ex_d.src_a = rs_val;
      endcase
      case (src_b)
         mips_pkg::SRC_B_SEXT: id_ex_d.src_b = {{16{inst_i.i.imm16[15]}}, inst_i.i.imm16};
         mips_pkg::SRC_B_ZEXT: id_ex_d.src_b = {16'd0, inst_i.i.imm16};
         default:              id_ex_d.src_b = rt_val;
      endcase
      id_ex_d.rt_data   = rt_val;
      id_ex_d.branch    = if_id_i.valid ? branch : mips_pkg::BR_NONE;
      id_ex_d.target    = inst_i[25:0];
      id_ex_d.mem_read  = if_id_i.valid & mem_read;
      id_ex_d.mem_write = if_id_i.valid & mem_write;
      id_ex_d.wb_en     = if_id_i.valid & wb_en & (wb_dest != '0);
      id_ex_d.wb_dest   = wb_dest;
   end

   always_ff @(posedge clk) begin
      if (rst || stall_i) begin
         id_ex_o.valid     <= 1'b0;
         id_ex_o.branch    <= mips_pkg::BR_NONE;
         id_ex_o.mem_read  <= 1'b0;
         id_ex_o.mem_write <= 1'b0;
         id_ex_o.wb_en     <= 1'b0;
      end else begin
         id_ex_o <= id_ex_d;
      end
   end

endmodule

`default_nettype wire

//--- rtl/hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
   input  wire  [mips_pkg::REG_ADDR_W-1:0] rs_i,
   input  wire  [mips_pkg::REG_ADDR_W-1:0] rt_i,
   input  wire  mips_pkg::id_ex_t          id_ex_i,
   input  wire  mips_pkg::ex_mem_t         ex_mem_i,
   input  wire                             redirect_i,
   output logic                            stall_o,
   output logic                            squash_o,
   output mips_pkg::fwd_sel_e              fwd_a_o,
   output mips_pkg::fwd_sel_e              fwd_b_o
);
   // Youngest producer wins
   function automatic mips_pkg::fwd_sel_e pick(
      input logic [mips_pkg::REG_ADDR_W-1:0] src,
      input mips_pkg::id_ex_t                ex,
      input mips_pkg::ex_mem_t               mem
   );
      if (src != '0 && ex.wb_en && ex.wb_dest == src)
         return mips_pkg::FWD_EX;
      if (src != '0 && mem.wb_en && mem.wb_dest == src)
         return mips_pkg::FWD_MEM;
      return mips_pkg::FWD_RF;
   endfunction

   assign fwd_a_o  = pick(rs_i, id_ex_i, ex_mem_i);
   assign fwd_b_o  = pick(rt_i, id_ex_i, ex_mem_i);
   assign stall_o  = id_ex_i.mem_read && id_ex_i.wb_dest != '0 &&
                     (id_ex_i.wb_dest == rs_i || id_ex_i.wb_dest == rt_i);
   assign squash_o = redirect_i;

   // A held branch would lose its delay slot
   always_comb begin
      assert final (!(stall_o && redirect_i)) else $error("stall during redirect");
   end

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage #(
   parameter logic [mips_pkg::XLEN-1:0] RESET_PC = 32'h0000_0000
) (
   input  wire                       clk,
   input  wire                       rst,
   input  wire                       stall_i,
   input  wire                       squash_i,
   input  wire                       redirect_i,
   input  wire  [mips_pkg::XLEN-1:0] target_i,
   output logic [mips_pkg::XLEN-1:0] inst_addr_o,
   output mips_pkg::if_id_t          if_id_o
);
   logic [mips_pkg::XLEN-1:0] pc_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         pc_q          <= RESET_PC;
         if_id_o.valid <= 1'b0;
      end else if (!stall_i) begin
         pc_q          <= redirect_i ? target_i : pc_q + 32'd4;
         if_id_o.valid <= !squash_i;
         if_id_o.pc    <= pc_q;
      end
   end

   // Refetch the word held in decode so it is on the bus again next cycle
   assign inst_addr_o = stall_i ? if_id_o.pc : pc_q;

   pc_aligned: assert property (@(posedge clk) disable iff (rst) pc_q[1:0] == 2'b00)
      else $error("fetch PC not word aligned");

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
   input  wire                             clk,
   input  wire                             rst,
   input  wire  [mips_pkg::REG_ADDR_W-1:0] raddr_a_i,
   input  wire  [mips_pkg::REG_ADDR_W-1:0] raddr_b_i,
   output logic [mips_pkg::XLEN-1:0]       rdata_a_o,
   output logic [mips_pkg::XLEN-1:0]       rdata_b_o,
   input  wire                             wen_i,
   input  wire  [mips_pkg::REG_ADDR_W-1:0] waddr_i,
   input  wire  [mips_pkg::XLEN-1:0]       wdata_i
);
   logic [mips_pkg::XLEN-1:0] regs [2**mips_pkg::REG_ADDR_W];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 2**mips_pkg::REG_ADDR_W; i++)
            regs[i] <= '0;
      end else if (wen_i) begin
         regs[waddr_i] <= wdata_i;
      end
   end

   // Write-through so decode sees the value retiring this cycle
   always_comb begin
      rdata_a_o = (wen_i && waddr_i == raddr_a_i) ? wdata_i : regs[raddr_a_i];
      rdata_b_o = (wen_i && waddr_i == raddr_b_i) ? wdata_i : regs[raddr_b_i];
      if (raddr_a_i == '0)
         rdata_a_o = '0;
      if (raddr_b_i == '0)
         rdata_b_o = '0;
   end

   no_r0_write: assert property (@(posedge clk) disable iff (rst) wen_i |-> waddr_i != '0)
      else $error("write to register 0");

endmodule

`default_nettype wire

//--- rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;

   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_J       = 6'h02,
      OP_JAL     = 6'h03,
      OP_BEQ     = 6'h04,
      OP_BNE     = 6'h05,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LW      = 6'h23,
      OP_SW      = 6'h2b
   } opcode_e;

   typedef enum logic [5:0] {
      FN_SLL  = 6'h00,
      FN_SRL  = 6'h02,
      FN_SRA  = 6'h03,
      FN_JR   = 6'h08,
      FN_ADDU = 6'h21,
      FN_SUBU = 6'h23,
      FN_AND  = 6'h24,
      FN_OR   = 6'h25,
      FN_XOR  = 6'h26,
      FN_NOR  = 6'h27,
      FN_SLT  = 6'h2a,
      FN_SLTU = 6'h2b
   } funct_e;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
      ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
   } alu_op_e;

   typedef enum logic [1:0] {SRC_A_REG, SRC_A_SHAMT, SRC_A_PC8} src_a_e;
   typedef enum logic [1:0] {SRC_B_REG, SRC_B_SEXT, SRC_B_ZEXT} src_b_e;

   typedef enum logic [2:0] {BR_NONE, BR_BEQ, BR_BNE, BR_J, BR_JR, BR_JAL} branch_e;

   typedef enum logic [1:0] {FWD_RF, FWD_EX, FWD_MEM} fwd_sel_e;

   typedef struct packed {
      opcode_e                opcode;
      logic [REG_ADDR_W-1:0]  rs;
      logic [REG_ADDR_W-1:0]  rt;
      logic [REG_ADDR_W-1:0]  rd;
      logic [4:0]             shamt;
      funct_e                 funct;
   } instr_r_t;

   typedef struct packed {
      opcode_e                opcode;
      logic [REG_ADDR_W-1:0]  rs;
      logic [REG_ADDR_W-1:0]  rt;
      logic [15:0]            imm16;
   } instr_i_t;

   // J-type index is the low 26 bits of either view
   typedef union packed {
      instr_r_t r;
      instr_i_t i;
   } instr_u;

   typedef struct packed {
      logic            valid;
      logic [XLEN-1:0] pc;
   } if_id_t;

   typedef struct packed {
      logic                  valid;
      logic [XLEN-1:0]       pc;
      alu_op_e               alu_op;
      logic [XLEN-1:0]       src_a;
      logic [XLEN-1:0]       src_b;
      logic [XLEN-1:0]       rt_data;
      branch_e               branch;
      logic [25:0]           target;
      logic                  mem_read;
      logic                  mem_write;
      logic                  wb_en;
      logic [REG_ADDR_W-1:0] wb_dest;
   } id_ex_t;

   typedef struct packed {
      logic                  valid;
      logic [XLEN-1:0]       pc;
      logic [XLEN-1:0]       result;
      logic                  mem_read;
      logic                  wb_en;
      logic [REG_ADDR_W-1:0] wb_dest;
   } ex_mem_t;

   typedef struct packed {
      logic                  valid;
      logic [XLEN-1:0]       pc;
      logic                  wb_en;
      logic [REG_ADDR_W-1:0] wb_dest;
      logic [XLEN-1:0]       wb_data;
   } mem_wb_t;

endpackage

`default_nettype wire
